//--- hw/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// instruction queue entries, also the source's starting credits
`define INSTR_FIFO_DEPTH 4

// commit records the sink can hold
`define COMMIT_CREDITS 2

`define REG_NUM 16
`define DATA_WIDTH 32

`endif

//--- hw/cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [3:0] reg_addr_t;

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLT  = 3'd5,
		OP_ADDI = 3'd6,
		OP_LUI  = 3'd7
	} opcode_t;

	// 32-bit instruction word
	typedef struct packed {
		opcode_t          opcode;
		reg_addr_t        rd;
		reg_addr_t        rs;
		reg_addr_t        rt;
		logic             unused;
		logic [15:0]      imm;
	} instr_t;

	typedef struct packed {
		logic                   valid;
		opcode_t                opcode;
		reg_addr_t              rd;
		logic [`DATA_WIDTH-1:0] op_a;
		logic [`DATA_WIDTH-1:0] op_b;
		logic [15:0]            imm;
	} pipeline_decode_t;

	// execute result and commit record
	typedef struct packed {
		logic                   valid;
		reg_addr_t              rd;
		logic [`DATA_WIDTH-1:0] wdata;
	} pipeline_commit_t;

endpackage

`default_nettype wire

//--- hw/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module instr_fetch import cpu_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire logic   instr_valid,
	input  wire instr_t instr,
	output logic        instr_credit,
	input  wire logic   fetch_ack,
	output logic        fetch_valid,
	output instr_t      fetch_instr
);

	localparam int DEPTH = `INSTR_FIFO_DEPTH;
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	instr_t        mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;

	assign fetch_valid = (count != '0);
	assign fetch_instr = mem[rd_ptr];

	// payload only, no reset
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			mem[wr_ptr] <= instr;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			instr_credit <= 1'b0;
		end else begin
			if (instr_valid) begin
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (fetch_ack) begin
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count        <= count + CW'(instr_valid) - CW'(fetch_ack);
			// one credit back per dequeued word
			instr_credit <= fetch_ack;
		end
	end

	// source must hold a credit for every word it sends
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid |-> (count != CW'(DEPTH)))
		else $error("instr_fetch: word pushed into full queue");

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_ack |-> fetch_valid)
		else $error("instr_fetch: pop from empty queue");

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module regfile import cpu_pkg::*; #(
	parameter int DATA_WIDTH = `DATA_WIDTH,
	parameter int REG_NUM    = `REG_NUM
) (
	input  wire logic                        clk,
	input  wire logic                        rst_n,
	input  wire logic                        we,
	input  wire reg_addr_t                   waddr,
	input  wire logic [DATA_WIDTH-1:0]       wdata,
	input  wire reg_addr_t [1:0]             raddr,
	output logic      [1:0][DATA_WIDTH-1:0]  rdata
);

	logic [REG_NUM-1:0][DATA_WIDTH-1:0] regs;

	// r0 is never written so it stays zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rdata[i] = regs[raddr[i]];
		end
	end

endmodule

`default_nettype wire

//--- hw/decode_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module decode_issue import cpu_pkg::*; (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          fetch_valid,
	input  wire instr_t                        fetch_instr,
	output logic                               fetch_ack,
	input  wire logic                          stall,
	output reg_addr_t [1:0]                    reg_raddr,
	input  wire logic [1:0][`DATA_WIDTH-1:0]   reg_rdata,
	input  wire pipeline_commit_t              exec_result,
	input  wire pipeline_commit_t              commit_fwd,
	output pipeline_decode_t                   pipeline_decode
);

	pipeline_decode_t decoded;
	logic [`DATA_WIDTH-1:0] src_a;
	logic [`DATA_WIDTH-1:0] src_b;
	logic [`DATA_WIDTH-1:0] imm_sext;

	// newest producer wins, r0 never forwarded
	function automatic logic [`DATA_WIDTH-1:0] forward(
		input reg_addr_t              addr,
		input logic [`DATA_WIDTH-1:0] rf_val,
		input pipeline_commit_t       ex,
		input pipeline_commit_t       cm
	);
		if (addr == '0) begin
			return rf_val;
		end else if (ex.valid && ex.rd == addr) begin
			return ex.wdata;
		end else if (cm.valid && cm.rd == addr) begin
			return cm.wdata;
		end
		return rf_val;
	endfunction

	assign reg_raddr[0] = fetch_instr.rs;
	assign reg_raddr[1] = fetch_instr.rt;

	assign src_a    = forward(fetch_instr.rs, reg_rdata[0], exec_result, commit_fwd);
	assign src_b    = forward(fetch_instr.rt, reg_rdata[1], exec_result, commit_fwd);
	assign imm_sext = {{(`DATA_WIDTH - 16){fetch_instr.imm[15]}}, fetch_instr.imm};

	assign fetch_ack = fetch_valid && !stall;

	always_comb begin
		decoded = '0;
		if (fetch_valid) begin
			decoded.valid  = 1'b1;
			decoded.opcode = fetch_instr.opcode;
			decoded.rd     = fetch_instr.rd;
			decoded.op_a   = src_a;
			decoded.imm    = fetch_instr.imm;
			if (fetch_instr.opcode inside {OP_ADDI, OP_LUI}) begin
				decoded.op_b = imm_sext;
			end else begin
				decoded.op_b = src_b;
			end
		end
	end

	// bubble when the queue is empty
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pipeline_decode <= '0;
		end else if (!stall) begin
			pipeline_decode <= decoded;
		end
	end

endmodule

`default_nettype wire

//--- hw/instr_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module instr_exec import cpu_pkg::*; (
	input  wire pipeline_decode_t pipeline_decode,
	output pipeline_commit_t      exec_result
);

	logic [`DATA_WIDTH-1:0] a;
	logic [`DATA_WIDTH-1:0] b;
	logic [`DATA_WIDTH-1:0] alu_out;

	assign a = pipeline_decode.op_a;
	assign b = pipeline_decode.op_b;

	always_comb begin
		alu_out = '0;
		case (pipeline_decode.opcode)
			OP_ADD: begin
				alu_out = a + b;
			end
			OP_SUB: begin
				alu_out = a - b;
			end
			OP_AND: begin
				alu_out = a & b;
			end
			OP_OR: begin
				alu_out = a | b;
			end
			OP_XOR: begin
				alu_out = a ^ b;
			end
			OP_SLT: begin
				alu_out = ($signed(a) < $signed(b)) ? `DATA_WIDTH'(1) : '0;
			end
			// b already holds the sign-extended immediate
			OP_ADDI: begin
				alu_out = a + b;
			end
			OP_LUI: begin
				alu_out = {pipeline_decode.imm, {(`DATA_WIDTH - 16){1'b0}}};
			end
			default: begin
				alu_out = '0;
			end
		endcase
	end

	always_comb begin
		exec_result.valid = pipeline_decode.valid;
		exec_result.rd    = pipeline_decode.rd;
		exec_result.wdata = alu_out;
	end

endmodule

`default_nettype wire

//--- hw/commit_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module commit_port import cpu_pkg::*; (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire pipeline_commit_t exec_result,
	output logic                  stall,
	output logic                  commit_valid,
	output pipeline_commit_t      commit,
	input  wire logic             commit_credit,
	output logic                  reg_we,
	output reg_addr_t             reg_waddr,
	output logic [`DATA_WIDTH-1:0] reg_wdata
);

	localparam int CW = $clog2(`COMMIT_CREDITS + 1);

	pipeline_commit_t commit_q;
	logic [CW-1:0]    credits;

	// record waits here until the sink has room
	assign commit_valid = commit_q.valid && (credits != '0);
	assign stall        = commit_q.valid && (credits == '0);
	assign commit       = commit_q;

	assign reg_we    = commit_valid;
	assign reg_waddr = commit_q.rd;
	assign reg_wdata = commit_q.wdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			commit_q <= '0;
			credits  <= CW'(`COMMIT_CREDITS);
		end else begin
			if (!stall) begin
				commit_q <= exec_result;
			end
			credits <= credits + CW'(commit_credit) - CW'(commit_valid);
		end
	end

	// sink never returns more than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= CW'(`COMMIT_CREDITS))
		else $error("commit_port: credit counter above %0d", `COMMIT_CREDITS);

endmodule

`default_nettype wire

//--- hw/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_core import cpu_pkg::*; (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire logic             instr_valid,
	input  wire instr_t           instr,
	output logic                  instr_credit,
	output logic                  commit_valid,
	output pipeline_commit_t      commit,
	input  wire logic             commit_credit
);

	logic   stall;
	logic   fetch_ack;
	logic   fetch_valid;
	instr_t fetch_instr;

	// register file ports
	logic                          reg_we;
	reg_addr_t                     reg_waddr;
	logic [`DATA_WIDTH-1:0]        reg_wdata;
	reg_addr_t [1:0]               reg_raddr;
	logic      [1:0][`DATA_WIDTH-1:0] reg_rdata;

	pipeline_decode_t pipeline_decode;
	pipeline_commit_t exec_result;

	instr_fetch instr_fetch_inst (
		.clk,
		.rst_n,
		.instr_valid,
		.instr,
		.instr_credit,
		.fetch_ack,
		.fetch_valid,
		.fetch_instr
	);

	regfile #(
		.DATA_WIDTH ( `DATA_WIDTH ),
		.REG_NUM    ( `REG_NUM    )
	) regfile_inst (
		.clk,
		.rst_n,
		.we    ( reg_we    ),
		.waddr ( reg_waddr ),
		.wdata ( reg_wdata ),
		.raddr ( reg_raddr ),
		.rdata ( reg_rdata )
	);

	decode_issue decode_issue_inst (
		.clk,
		.rst_n,
		.fetch_valid,
		.fetch_instr,
		.fetch_ack,
		.stall,
		.reg_raddr,
		.reg_rdata,
		.exec_result,
		.commit_fwd ( commit ),
		.pipeline_decode
	);

	instr_exec instr_exec_inst (
		.pipeline_decode,
		.exec_result
	);

	commit_port commit_port_inst (
		.clk,
		.rst_n,
		.exec_result,
		.stall,
		.commit_valid,
		.commit,
		.commit_credit,
		.reg_we,
		.reg_waddr,
		.reg_wdata
	);

endmodule

`default_nettype wire

//--- testbench/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu_core import cpu_pkg::*; ();

	logic             clk;
	logic             rst_n;
	logic             instr_valid;
	instr_t           instr;
	logic             instr_credit;
	logic             commit_valid;
	pipeline_commit_t commit;
	logic             commit_credit;

	// source, sink and reference model state
	instr_t           send_q[$];
	pipeline_commit_t exp_q[$];
	logic [31:0]      model_regs [16];
	logic [31:0]      lfsr;
	int               src_credits;
	int               outstanding;
	int               credits_back;
	int               sink_credits;
	int               pending_returns;
	int               hold_cnt;
	int               commits_seen;
	bit               slow_sink;
	bit               aborted;
	int               errors;
	int               tests_run;
	int               tests_ok;

	cpu_core dut0 (
		.clk,
		.rst_n,
		.instr_valid,
		.instr,
		.instr_credit,
		.commit_valid,
		.commit,
		.commit_credit
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %s: got %08h expected %08h", name, got, exp);
			errors++;
		end
	endtask

	function automatic instr_t make_instr(input opcode_t op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt, input logic [15:0] imm);
		instr_t w;
		w.opcode = op;
		w.rd     = rd;
		w.rs     = rs;
		w.rt     = rt;
		w.unused = 1'b0;
		w.imm    = imm;
		return w;
	endfunction

	function automatic logic [31:0] model_result(input instr_t w);
		logic [31:0] a;
		logic [31:0] b;
		a = model_regs[w.rs];
		b = model_regs[w.rt];
		case (w.opcode)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_ADDI: return a + {{16{w.imm[15]}}, w.imm};
			default: return {w.imm, 16'h0000};
		endcase
	endfunction

	// program order update of the model, then queue the word for the source
	task automatic issue(input instr_t w);
		pipeline_commit_t e;
		e.valid = 1'b1;
		e.rd    = w.rd;
		e.wdata = model_result(w);
		if (w.rd != 4'd0) begin
			model_regs[w.rd] = e.wdata;
		end
		exp_q.push_back(e);
		send_q.push_back(w);
	endtask

	task automatic drive_inputs();
		// the core took last cycle's credit at the edge just passed
		if (commit_credit) begin
			sink_credits++;
		end
		instr_valid   = 1'b0;
		commit_credit = 1'b0;
		if (send_q.size() > 0 && src_credits > 0) begin
			instr       = send_q.pop_front();
			instr_valid = 1'b1;
			src_credits--;
			outstanding++;
			if (outstanding > `INSTR_FIFO_DEPTH) begin
				$display("source has %0d words outstanding, more than the queue holds", outstanding);
				errors++;
			end
		end
		if (pending_returns > 0) begin
			if (hold_cnt > 0) begin
				hold_cnt--;
			end else begin
				commit_credit = 1'b1;
				pending_returns--;
				if (slow_sink) begin
					hold_cnt = int'(rand_bits(5));
				end
			end
		end
	endtask

	task automatic observe_outputs();
		pipeline_commit_t e;
		if (instr_credit) begin
			credits_back++;
			src_credits++;
			outstanding--;
			if (outstanding < 0) begin
				$display("instr_credit returned with no word outstanding");
				errors++;
			end
		end
		if (commit_valid) begin
			commits_seen++;
			pending_returns++;
			if (sink_credits == 0) begin
				$display("commit_valid high while the sink holds no credit");
				errors++;
			end else begin
				sink_credits--;
			end
			check_value("commit.valid", 32'(commit.valid), 32'd1);
			if (exp_q.size() == 0) begin
				$display("commit record arrived with no instruction expected");
				errors++;
			end else begin
				e = exp_q.pop_front();
				check_value("commit.rd", 32'(commit.rd), 32'(e.rd));
				check_value("commit.wdata", commit.wdata, e.wdata);
			end
		end
	endtask

	// drive shortly after the rising edge, sample on the falling edge
	task automatic step_cycle();
		@(posedge clk);
		#1;
		drive_inputs();
		@(negedge clk);
		observe_outputs();
	endtask

	task automatic wait_drain(input int limit);
		int cycles;
		cycles = 0;
		while (send_q.size() != 0 || exp_q.size() != 0 || pending_returns != 0
			|| src_credits != `INSTR_FIFO_DEPTH) begin
			step_cycle();
			cycles++;
			if (cycles > limit) begin
				$display("timeout: pipeline did not drain within %0d cycles", limit);
				errors++;
				aborted = 1'b1;
				break;
			end
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			tests_ok++;
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
		end
	endtask

	task automatic test_idle();
		int err0;
		err0 = errors;
		for (int i = 0; i < 10; i++) begin
			step_cycle();
			check_value("commit_valid", 32'(commit_valid), 32'd0);
			check_value("instr_credit", 32'(instr_credit), 32'd0);
		end
		finish_test("idle after reset", err0);
	endtask

	task automatic test_opcodes();
		int err0;
		err0 = errors;
		issue(make_instr(OP_LUI, 4'd1, 4'd0, 4'd0, 16'h1234));
		issue(make_instr(OP_ADDI, 4'd1, 4'd1, 4'd0, 16'h5678));
		issue(make_instr(OP_LUI, 4'd2, 4'd0, 4'd0, 16'hff00));
		issue(make_instr(OP_ADDI, 4'd2, 4'd2, 4'd0, 16'h00f0));
		issue(make_instr(OP_ADD, 4'd3, 4'd1, 4'd2, 16'h0000));
		issue(make_instr(OP_SUB, 4'd4, 4'd1, 4'd2, 16'h0000));
		issue(make_instr(OP_AND, 4'd5, 4'd1, 4'd2, 16'h0000));
		issue(make_instr(OP_OR, 4'd6, 4'd1, 4'd2, 16'h0000));
		issue(make_instr(OP_XOR, 4'd7, 4'd1, 4'd2, 16'h0000));
		// r2 is negative, so r2 < r1 only when compared signed
		issue(make_instr(OP_SLT, 4'd8, 4'd2, 4'd1, 16'h0000));
		issue(make_instr(OP_SLT, 4'd9, 4'd1, 4'd2, 16'h0000));
		issue(make_instr(OP_ADDI, 4'd10, 4'd1, 4'd0, 16'h8000));
		issue(make_instr(OP_LUI, 4'd0, 4'd0, 4'd0, 16'habcd));
		issue(make_instr(OP_ADD, 4'd11, 4'd0, 4'd1, 16'h0000));
		issue(make_instr(OP_OR, 4'd12, 4'd0, 4'd0, 16'h0000));
		wait_drain(500);
		finish_test("opcodes", err0);
	endtask

	task automatic test_forwarding();
		int err0;
		logic [3:0] cur;
		logic [3:0] prev;
		logic [3:0] prev2;
		err0 = errors;
		issue(make_instr(OP_LUI, 4'd5, 4'd0, 4'd0, 16'h0003));
		issue(make_instr(OP_ADDI, 4'd6, 4'd5, 4'd0, 16'h0007));
		prev2 = 4'd5;
		prev  = 4'd6;
		// each word reads the previous rd and the one before it
		for (int i = 0; i < 16; i++) begin
			cur = 4'(5 + (i % 3));
			case (i % 4)
				0: issue(make_instr(OP_ADD, cur, prev, prev2, 16'h0000));
				1: issue(make_instr(OP_SUB, cur, prev, prev2, 16'h0000));
				2: issue(make_instr(OP_XOR, cur, prev2, prev, 16'h0000));
				default: issue(make_instr(OP_ADDI, cur, prev, 4'd0, 16'h0011));
			endcase
			prev2 = prev;
			prev  = cur;
		end
		wait_drain(500);
		finish_test("dependent chain", err0);
	endtask

	task automatic test_random(input bit slow, input string name, input int limit);
		int err0;
		int back0;
		int seen0;
		instr_t w;
		err0      = errors;
		back0     = credits_back;
		seen0     = commits_seen;
		slow_sink = slow;
		hold_cnt  = slow ? int'(rand_bits(5)) : 0;
		for (int i = 0; i < 200; i++) begin
			w        = instr_t'(rand_bits(32));
			w.unused = 1'b0;
			issue(w);
		end
		wait_drain(limit);
		check_value("instr_credit pulses", 32'(credits_back - back0), 32'd200);
		check_value("commit records", 32'(commits_seen - seen0), 32'd200);
		slow_sink = 1'b0;
		finish_test(name, err0);
	endtask

	initial begin
		rst_n           = 1'b0;
		instr_valid     = 1'b0;
		instr           = '0;
		commit_credit   = 1'b0;
		lfsr            = 32'd83909;
		src_credits     = `INSTR_FIFO_DEPTH;
		outstanding     = 0;
		credits_back    = 0;
		sink_credits    = `COMMIT_CREDITS;
		pending_returns = 0;
		hold_cnt        = 0;
		commits_seen    = 0;
		slow_sink       = 1'b0;
		aborted         = 1'b0;
		errors          = 0;
		tests_run       = 0;
		tests_ok        = 0;
		for (int i = 0; i < 16; i++) begin
			model_regs[i] = 32'd0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_idle();
		if (!aborted) begin
			test_opcodes();
		end
		if (!aborted) begin
			test_forwarding();
		end
		if (!aborted) begin
			test_random(1'b0, "random with free sink", 5000);
		end
		if (!aborted) begin
			test_random(1'b1, "random with slow sink", 20000);
		end

		$display("summary: %0d tests run, %0d ok, %0d check errors", tests_run, tests_ok, errors);
		if (errors == 0 && tests_ok == tests_run) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cpu_core.f
+incdir+hw
hw/cpu_pkg.sv
hw/instr_fetch.sv
hw/regfile.sv
hw/decode_issue.sv
hw/instr_exec.sv
hw/commit_port.sv
hw/cpu_core.sv
testbench/tb_cpu_core.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cpu_core -f cpu_core.f -o sim_cpu_core \
	&& ./obj_dir/sim_cpu_core > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -qx "all tests passed" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
